// File: flist.f
verilog/krv_cfg_pkg.sv
verilog/krv_dbus_pkg.sv
verilog/dbus_req_stage.sv
verilog/dbus_trans_buffer.sv
verilog/dtcm.sv
verilog/krv_dmem_top.sv
dv/dmem_checker.sv
dv/tb_krv_dmem.sv

// File: Bender.yml
package:
  name: krv_dmem

sources:
  - verilog/krv_cfg_pkg.sv
  - verilog/krv_dbus_pkg.sv
  - verilog/dbus_req_stage.sv
  - verilog/dbus_trans_buffer.sv
  - verilog/dtcm.sv
  - verilog/krv_dmem_top.sv
  - target: test
    files:
      - dv/dmem_checker.sv
      - dv/tb_krv_dmem.sv

// File: dv/tb_krv_dmem.sv
////////////////////////////////////////////////////////////
// Testbench for the data-memory path. Applies a table of
// loads and stores and lets the checker compare every load
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_krv_dmem;

	import krv_cfg_pkg::*;
	import krv_dbus_pkg::*;

	localparam int DTCM_WORDS = 256;
	localparam int BUF_DEPTH  = 4;
	// Slot and buffer full of sub-word stores, plus some margin
	localparam int DRAIN_CYCLES = 2 * (BUF_DEPTH + 1) + 8;

	typedef struct packed {
		logic         rd0_wr1;
		access_size_t size;
		logic [31:0]  addr;
		logic [31:0]  wdata;
		logic         rnd;
		logic [7:0]   gap;
	} stim_t;

	logic                  cpu_clk = 1'b0;
	logic                  rst;
	logic                  data_access;
	dbus_access_t          data_req;
	logic                  trans_buffer_full;
	logic [DATA_WIDTH-1:0] read_data;
	logic                  read_data_valid;
	int                    errors;
	int                    checks;
	int                    pending;
	logic                  full_seen;
	stim_t                 stim_q [$];
	logic [31:0]           lcg_state = 32'd54;
	int                    tb_errors = 0;
	int                    cycles = 0;
	int                    cycle_limit = 1000;
	int                    drain = 0;

	always #2 cpu_clk = ~cpu_clk;

	krv_dmem_top #(
		.DTCM_WORDS (DTCM_WORDS),
		.BUF_DEPTH  (BUF_DEPTH)
	) DUT (
		.cpu_clk           (cpu_clk),
		.rst               (rst),
		.data_access       (data_access),
		.data_req          (data_req),
		.trans_buffer_full (trans_buffer_full),
		.read_data         (read_data),
		.read_data_valid   (read_data_valid)
	);

	dmem_checker #(
		.DTCM_WORDS (DTCM_WORDS)
	) u_dmem_checker (
		.cpu_clk           (cpu_clk),
		.rst               (rst),
		.data_access       (data_access),
		.data_req          (data_req),
		.trans_buffer_full (trans_buffer_full),
		.read_data         (read_data),
		.read_data_valid   (read_data_valid),
		.errors            (errors),
		.checks            (checks),
		.pending           (pending),
		.full_seen         (full_seen)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_entry(input logic wr, input access_size_t size, input logic [31:0] addr,
	                         input logic [31:0] wdata, input logic rnd, input int gap);
		stim_q.push_back({wr, size, addr, wdata, rnd, 8'(gap)});
	endtask

	task automatic build_table();
		// Word store and loads of the same word direct and through the wrap
		add_entry(1, SIZE_WORD, 32'h10, 32'hdead_beef, 0, 1);
		add_entry(0, SIZE_WORD, 32'h10, 0, 0, 0);
		add_entry(0, SIZE_WORD, 32'h410, 0, 0, 2);
		add_entry(1, SIZE_WORD, 32'h824, 0, 1, 0);
		add_entry(0, SIZE_WORD, 32'h24, 0, 0, 1);
		// Byte and half merged into the word at 0x10
		add_entry(1, SIZE_BYTE, 32'h11, 32'h0000_00a5, 0, 0);
		add_entry(1, SIZE_HALF, 32'h12, 32'h0000_1234, 0, 0);
		add_entry(0, SIZE_WORD, 32'h10, 0, 0, 2);
		for (int i = 0; i < 4; i++) begin
			add_entry(0, SIZE_BYTE, 32'h10 + i, 0, 0, i % 2);
		end
		add_entry(0, SIZE_HALF, 32'h10, 0, 0, 0);
		add_entry(0, SIZE_HALF, 32'h12, 0, 0, 3);
		// Sub-word stores without gaps so the DTCM falls behind and full rises
		for (int i = 0; i < 8; i++) begin
			add_entry(1, SIZE_BYTE, 32'h40 + i, 0, 1, 0);
		end
		add_entry(1, SIZE_HALF, 32'h48, 0, 1, 0);
		add_entry(1, SIZE_HALF, 32'h4a, 0, 1, 0);
		add_entry(0, SIZE_WORD, 32'h40, 0, 0, 0);
		add_entry(0, SIZE_WORD, 32'h44, 0, 0, 0);
		add_entry(0, SIZE_BYTE, 32'h45, 0, 0, 0);
		add_entry(0, SIZE_HALF, 32'h4a, 0, 0, 0);
		add_entry(0, SIZE_WORD, 32'h48, 0, 0, 0);
	endtask

	// Starts and ends on a falling edge
	task automatic apply_entry(input stim_t e);
		data_req.rd0_wr1    = e.rd0_wr1;
		data_req.size       = e.size;
		data_req.addr       = e.addr;
		data_req.write_data = e.rnd ? next_random() : e.wdata;
		data_access         = 1'b1;
		while (trans_buffer_full) begin
			@(negedge cpu_clk);
		end
		@(negedge cpu_clk);
		data_access = 1'b0;
		repeat (e.gap) @(negedge cpu_clk);
	endtask

	always @(posedge cpu_clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout after %0d cycles with %0d loads pending", cycles, pending);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		rst         = 1'b1;
		data_access = 1'b0;
		data_req    = '0;
		build_table();
		cycle_limit = 12 * stim_q.size() + 100;
		repeat (5) @(negedge cpu_clk);
		rst = 1'b0;
		// Idle window with outputs low
		repeat (4) @(negedge cpu_clk);
		foreach (stim_q[i]) begin
			apply_entry(stim_q[i]);
		end
		while (pending != 0 && drain < DRAIN_CYCLES) begin
			@(negedge cpu_clk);
			drain++;
		end
		repeat (3) @(negedge cpu_clk);
		if (!full_seen) begin
			$display("Error: trans_buffer_full never rose during back-to-back stores");
			tb_errors++;
		end
		if (pending != 0) begin
			$display("Error: %0d loads still pending after the last access", pending);
			tb_errors++;
		end
		$display("Errors: %0d checker, %0d testbench; %0d loads compared",
		         errors, tb_errors, checks);
		if (errors == 0 && tb_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/dmem_checker.sv
////////////////////////////////////////////////////////////
// Testbench checker for the data-memory path: byte shadow
// of the DTCM, expected-load queue and error counting
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dmem_checker #(
	parameter int DTCM_WORDS = krv_cfg_pkg::DEF_DTCM_WORDS
) (
	input  wire logic                                cpu_clk,
	input  wire logic                                rst,
	input  wire logic                                data_access,
	input  wire krv_dbus_pkg::dbus_access_t          data_req,
	input  wire logic                                trans_buffer_full,
	input  wire logic [krv_cfg_pkg::DATA_WIDTH-1:0]  read_data,
	input  wire logic                                read_data_valid,
	output int                                       errors,
	output int                                       checks,
	output int                                       pending,
	output logic                                     full_seen
);

	import krv_cfg_pkg::*;
	import krv_dbus_pkg::*;

	localparam int MEM_BYTES = DTCM_WORDS * STRB_WIDTH;

	logic [7:0]            shadow [MEM_BYTES];
	logic [DATA_WIDTH-1:0] expect_q [$];
	logic [DATA_WIDTH-1:0] exp_val;
	logic                  seen_access;
	int                    base;
	int                    ix;

	initial begin
		errors      = 0;
		checks      = 0;
		pending     = 0;
		full_seen   = 1'b0;
		seen_access = 1'b0;
	end

	always @(posedge cpu_clk) begin
		if (!rst) begin
			// Outputs stay quiet until the first access
			if (!seen_access && (read_data_valid || trans_buffer_full)) begin
				$display("Error: DUT output active before any access at %0t", $time);
				errors++;
			end
			if (trans_buffer_full) begin
				full_seen = 1'b1;
			end
			if (read_data_valid) begin
				if (expect_q.size() == 0) begin
					$display("Error: read_data_valid with no load outstanding at %0t", $time);
					errors++;
				end else begin
					exp_val = expect_q.pop_front();
					checks++;
					if (read_data !== exp_val) begin
						$display("[FAIL] read_data expected 0x%08h actual 0x%08h",
						         exp_val, read_data);
						errors++;
					end
				end
			end
			if (data_access && !trans_buffer_full) begin
				seen_access = 1'b1;
				base = int'({data_req.addr[ADDR_WIDTH-1:2], 2'b00} % MEM_BYTES);
				ix   = int'(data_req.addr % MEM_BYTES);
				if (data_req.rd0_wr1) begin
					case (data_req.size)
						SIZE_BYTE: shadow[ix] = data_req.write_data[7:0];
						SIZE_HALF: begin
							// Half lanes picked by addr[1] only
							shadow[base + 2*data_req.addr[1]]     = data_req.write_data[7:0];
							shadow[base + 2*data_req.addr[1] + 1] = data_req.write_data[15:8];
						end
						default: begin
							for (int i = 0; i < STRB_WIDTH; i++) begin
								shadow[base + i] = data_req.write_data[8*i +: 8];
							end
						end
					endcase
				end else begin
					case (data_req.size)
						SIZE_BYTE: exp_val = {24'h0, shadow[ix]};
						SIZE_HALF: exp_val = {16'h0, shadow[ix + 1], shadow[ix]};
						default:   exp_val = {shadow[base + 3], shadow[base + 2],
						                      shadow[base + 1], shadow[base]};
					endcase
					expect_q.push_back(exp_val);
				end
			end
			pending = expect_q.size();
		end
	end

endmodule

`default_nettype wire

// File: verilog/krv_dmem_top.sv
////////////////////////////////////////////////////////////
// Data-memory path top: request stage, transaction buffer
// and DTCM in a chain; sets the depths for both memories
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module krv_dmem_top #(
	parameter int DTCM_WORDS = krv_cfg_pkg::DEF_DTCM_WORDS,
	parameter int BUF_DEPTH  = krv_cfg_pkg::DEF_BUF_DEPTH
) (
	input  wire logic                           cpu_clk,
	input  wire logic                           rst,
	input  wire logic                           data_access,
	input  wire krv_dbus_pkg::dbus_access_t     data_req,
	output logic                                trans_buffer_full,
	output logic [krv_cfg_pkg::DATA_WIDTH-1:0]  read_data,
	output logic                                read_data_valid
);

	import krv_dbus_pkg::*;

	dbus_req_t req;
	logic      req_valid;
	logic      buf_full;
	dbus_req_t head;
	logic      head_valid;
	logic      head_ready;

	dbus_req_stage u_req_stage (
		.cpu_clk           (cpu_clk),
		.rst               (rst),
		.data_access       (data_access),
		.data_req          (data_req),
		.buf_full          (buf_full),
		.req               (req),
		.req_valid         (req_valid),
		.trans_buffer_full (trans_buffer_full)
	);

	dbus_trans_buffer #(
		.BUF_DEPTH (BUF_DEPTH)
	) u_trans_buffer (
		.cpu_clk    (cpu_clk),
		.rst        (rst),
		.req        (req),
		.req_valid  (req_valid),
		.buf_full   (buf_full),
		.head       (head),
		.head_valid (head_valid),
		.head_ready (head_ready)
	);

	dtcm #(
		.DTCM_WORDS (DTCM_WORDS)
	) u_dtcm (
		.cpu_clk         (cpu_clk),
		.rst             (rst),
		.head            (head),
		.head_valid      (head_valid),
		.head_ready      (head_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid)
	);

endmodule

`default_nettype wire

// File: verilog/dtcm.sv
////////////////////////////////////////////////////////////
// Data TCM: performs queued requests in order, merges
// sub-word stores in two cycles, returns aligned load data
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dtcm #(
	parameter int DTCM_WORDS = 256
) (
	input  wire logic                                cpu_clk,
	input  wire logic                                rst,
	input  wire krv_dbus_pkg::dbus_req_t             head,
	input  wire logic                                head_valid,
	output logic                                     head_ready,
	output logic [krv_cfg_pkg::DATA_WIDTH-1:0]       read_data,
	output logic                                     read_data_valid
);

	import krv_cfg_pkg::*;

	localparam int IDX_W = (DTCM_WORDS > 1) ? $clog2(DTCM_WORDS) : 1;

	typedef enum logic {
		ST_IDLE,
		ST_MERGE
	} state_t;

	state_t                state;
	logic [DATA_WIDTH-1:0] mem [DTCM_WORDS];
	logic [IDX_W-1:0]      idx;
	logic                  is_load;
	logic                  is_word_store;
	logic                  is_sub_store;
	logic [DATA_WIDTH-1:0] merge_q;
	logic [DATA_WIDTH-1:0] merged;
	logic [DATA_WIDTH-1:0] rd_word_q;
	logic [DATA_WIDTH-1:0] rd_shift;
	logic [1:0]            rd_off_q;
	access_size_t          rd_size_q;

	// Addresses beyond the array wrap around
	assign idx = IDX_W'(head.word_addr % DTCM_WORDS);

	assign is_load       = head_valid && !head.rd0_wr1;
	assign is_word_store = head_valid && head.rd0_wr1 && (&head.byte_strobe);
	assign is_sub_store  = head_valid && head.rd0_wr1 && !(&head.byte_strobe);

	// Hold the head while the old word is fetched
	assign head_ready = (state == ST_MERGE) || !is_sub_store;

	always_comb begin
		for (int i = 0; i < STRB_WIDTH; i++) begin
			merged[8*i +: 8] = head.byte_strobe[i] ? head.write_data[8*i +: 8]
			                                       : merge_q[8*i +: 8];
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			state           <= ST_IDLE;
			read_data_valid <= 1'b0;
		end else begin
			read_data_valid <= is_load;
			case (state)
				ST_IDLE: begin
					if (is_sub_store) begin
						state <= ST_MERGE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Single port: one read or one write per cycle
	always_ff @(posedge cpu_clk) begin
		if (state == ST_MERGE) begin
			mem[idx] <= merged;
		end else if (is_word_store) begin
			mem[idx] <= head.write_data;
		end else if (is_sub_store) begin
			merge_q <= mem[idx];
		end else if (is_load) begin
			rd_word_q <= mem[idx];
			rd_off_q  <= head.byte_offset;
			rd_size_q <= head.size;
		end
	end

	// Addressed lanes down to bit 0, then zero-extend
	assign rd_shift = rd_word_q >> {rd_off_q, 3'b000};

	always_comb begin
		case (rd_size_q)
			SIZE_BYTE: read_data = {24'h0, rd_shift[7:0]};
			SIZE_HALF: read_data = {16'h0, rd_shift[15:0]};
			default:   read_data = rd_shift;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/dbus_trans_buffer.sv
////////////////////////////////////////////////////////////
// Circular FIFO of data-bus requests between the request
// stage and the DTCM; depth is any power of two
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbus_trans_buffer #(
	parameter int BUF_DEPTH = 4
) (
	input  wire logic                     cpu_clk,
	input  wire logic                     rst,
	input  wire krv_dbus_pkg::dbus_req_t  req,
	input  wire logic                     req_valid,
	output logic                          buf_full,
	output krv_dbus_pkg::dbus_req_t       head,
	output logic                          head_valid,
	input  wire logic                     head_ready
);

	import krv_dbus_pkg::*;

	localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUF_DEPTH + 1);

	dbus_req_t        entries [BUF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Explicit wrap keeps a depth of one in range
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign buf_full   = (count == CNT_W'(BUF_DEPTH));
	assign head_valid = (count != '0);
	assign head       = entries[rd_ptr];

	assign push = req_valid && !buf_full;
	assign pop  = head_valid && head_ready;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Storage carries no reset
	always_ff @(posedge cpu_clk) begin
		if (push) begin
			entries[wr_ptr] <= req;
		end
	end

endmodule

`default_nettype wire

// File: verilog/dbus_req_stage.sv
////////////////////////////////////////////////////////////
// Registers one core access, forms byte strobes and lane
// data, and drives the buffer-full level back to the core
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dbus_req_stage (
	input  wire logic                        cpu_clk,
	input  wire logic                        rst,
	input  wire logic                        data_access,
	input  wire krv_dbus_pkg::dbus_access_t  data_req,
	input  wire logic                        buf_full,
	output krv_dbus_pkg::dbus_req_t          req,
	output logic                             req_valid,
	output logic                             trans_buffer_full
);

	import krv_cfg_pkg::*;
	import krv_dbus_pkg::*;

	logic                  push;
	logic                  accept;
	logic [STRB_WIDTH-1:0] strb_d;
	logic [DATA_WIDTH-1:0] wdata_d;
	dbus_req_t             req_d;

	// Slot drains into the buffer whenever the buffer has room
	assign push = req_valid && !buf_full;

	// Full only when the slot is stuck behind a full buffer
	assign trans_buffer_full = req_valid && buf_full;
	assign accept = data_access && !trans_buffer_full;

	// Lane select and data replication by size
	always_comb begin
		case (data_req.size)
			SIZE_BYTE: begin
				strb_d  = 4'b0001 << data_req.addr[1:0];
				wdata_d = {4{data_req.write_data[7:0]}};
			end
			SIZE_HALF: begin
				strb_d  = data_req.addr[1] ? 4'b1100 : 4'b0011;
				wdata_d = {2{data_req.write_data[15:0]}};
			end
			default: begin
				strb_d  = {STRB_WIDTH{1'b1}};
				wdata_d = data_req.write_data;
			end
		endcase
	end

	always_comb begin
		req_d.rd0_wr1     = data_req.rd0_wr1;
		req_d.size        = data_req.size;
		req_d.word_addr   = data_req.addr[ADDR_WIDTH-1:2];
		req_d.byte_offset = data_req.addr[1:0];
		req_d.byte_strobe = strb_d;
		req_d.write_data  = wdata_d;
	end

	// A new access may land in the same edge the old one leaves
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			req_valid <= 1'b0;
		end else if (accept) begin
			req_valid <= 1'b1;
		end else if (push) begin
			req_valid <= 1'b0;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (accept) begin
			req <= req_d;
		end
	end

endmodule

`default_nettype wire

// File: verilog/krv_dbus_pkg.sv
////////////////////////////////////////////////////////////
// Data-bus request and response records used between the
// request stage, the transaction buffer and the DTCM
////////////////////////////////////////////////////////////

`default_nettype none

package krv_dbus_pkg;

	// Access as the core presents it, one cycle wide
	typedef struct packed {
		logic                                  rd0_wr1;
		krv_cfg_pkg::access_size_t             size;
		logic [krv_cfg_pkg::ADDR_WIDTH-1:0]    addr;
		logic [krv_cfg_pkg::DATA_WIDTH-1:0]    write_data;
	} dbus_access_t;

	// Queued request, already split into word and lanes
	typedef struct packed {
		logic                                  rd0_wr1;
		krv_cfg_pkg::access_size_t             size;
		logic [krv_cfg_pkg::ADDR_WIDTH-3:0]    word_addr;
		logic [1:0]                            byte_offset;
		logic [krv_cfg_pkg::STRB_WIDTH-1:0]    byte_strobe;
		// Replicated into every lane the strobes select
		logic [krv_cfg_pkg::DATA_WIDTH-1:0]    write_data;
	} dbus_req_t;

endpackage

`default_nettype wire

// File: verilog/krv_cfg_pkg.sv
////////////////////////////////////////////////////////////
// Widths, default depths and the access size code shared
// by every block of the data-memory path
////////////////////////////////////////////////////////////

`default_nettype none

package krv_cfg_pkg;

	// Bus widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	// Defaults picked up by the top level
	localparam int DEF_DTCM_WORDS = 256;
	localparam int DEF_BUF_DEPTH  = 4;

	// Access size as issued by the core
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0,
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_t;

endpackage

`default_nettype wire
